// ==== source/periph_cfg.svh ====
// Sizes and widths shared by the peripheral subsystem
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus widths
`define PERIPH_DATA_W    32
`define PERIPH_ADDR_W    16

// Low address bits select a register inside a region
`define PERIPH_OFFSET_W  12

// Interrupt sources, id 0 stays unused
`define PERIPH_NUM_SRC   8
`define PERIPH_PRIO_W    3

// Timer block
`define PERIPH_TIMER_CNT 2

`endif

// ==== source/periph_bus_pkg.sv ====
// Peripheral bus address map and the two views of a bus address
`default_nettype none

`include "periph_cfg.svh"

package periph_bus_pkg;

    localparam int REGION_W = `PERIPH_ADDR_W - `PERIPH_OFFSET_W;

    // Upper address bits pick the peripheral
    typedef enum logic [REGION_W-1:0] {
        REGION_IRQ   = 'd0,
        REGION_TIMER = 'd1,
        REGION_GPIO  = 'd2
    } region_e;

    typedef logic [`PERIPH_OFFSET_W-1:0] offset_t;

    typedef struct packed {
        region_e region;
        offset_t offset;
    } periph_addr_s;

    // Raw word for alignment checks, fields for routing
    typedef union packed {
        logic [`PERIPH_ADDR_W-1:0] raw;
        periph_addr_s              fields;
    } periph_addr_u;

    // Returned for any region with no peripheral behind it
    localparam logic [`PERIPH_DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

endpackage

`default_nettype wire

// ==== source/periph_irq_pkg.sv ====
// Interrupt source numbering and interrupt controller types
`default_nettype none

`include "periph_cfg.svh"

package periph_irq_pkg;

    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    typedef logic [$clog2(`PERIPH_NUM_SRC)-1:0] src_id_t;

    // Claim value when nothing is pending
    localparam src_id_t SRC_NONE = '0;

    // Timer n raises source TIMER_FIRST_SRC + n
    localparam int TIMER_FIRST_SRC = 1;

endpackage

`default_nettype wire

// ==== source/apb_if.sv ====
// APB link from the address decoder to one peripheral
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

interface apb_if;

    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    periph_bus_pkg::offset_t    paddr;
    logic [`PERIPH_DATA_W-1:0]  pwdata;
    logic [`PERIPH_DATA_W-1:0]  prdata;
    logic                       pready;
    logic                       pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

// ==== source/apb_decoder.sv ====
// APB region decoder with read mux and error response for unmapped regions
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

module apb_decoder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  periph_bus_pkg::periph_addr_u paddr_i,
    input  logic [`PERIPH_DATA_W-1:0]   pwdata_i,
    output logic [`PERIPH_DATA_W-1:0]   prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    apb_if.master                       irq_bus,
    apb_if.master                       timer_bus,
    apb_if.master                       gpio_bus
);

    import periph_bus_pkg::*;

    region_e region;

    assign region = paddr_i.fields.region;

    // ------------------------------
    // Request side
    // ------------------------------
    assign irq_bus.psel      = psel_i && (region == REGION_IRQ);
    assign irq_bus.penable   = penable_i;
    assign irq_bus.pwrite    = pwrite_i;
    assign irq_bus.paddr     = paddr_i.fields.offset;
    assign irq_bus.pwdata    = pwdata_i;

    assign timer_bus.psel    = psel_i && (region == REGION_TIMER);
    assign timer_bus.penable = penable_i;
    assign timer_bus.pwrite  = pwrite_i;
    assign timer_bus.paddr   = paddr_i.fields.offset;
    assign timer_bus.pwdata  = pwdata_i;

    assign gpio_bus.psel     = psel_i && (region == REGION_GPIO);
    assign gpio_bus.penable  = penable_i;
    assign gpio_bus.pwrite   = pwrite_i;
    assign gpio_bus.paddr    = paddr_i.fields.offset;
    assign gpio_bus.pwdata   = pwdata_i;

    // ------------------------------
    // Response side
    // ------------------------------
    always_comb begin
        // Unmapped region answers at once with an error
        prdata_o  = ERR_RDATA;
        pready_o  = 1'b1;
        pslverr_o = psel_i && penable_i;
        case (region)
            REGION_IRQ: begin
                prdata_o  = irq_bus.prdata;
                pready_o  = irq_bus.pready;
                pslverr_o = irq_bus.pslverr;
            end
            REGION_TIMER: begin
                prdata_o  = timer_bus.prdata;
                pready_o  = timer_bus.pready;
                pslverr_o = timer_bus.pslverr;
            end
            REGION_GPIO: begin
                prdata_o  = gpio_bus.prdata;
                pready_o  = gpio_bus.pready;
                pslverr_o = gpio_bus.pslverr;
            end
            default: ;
        endcase
    end

    sel_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({irq_bus.psel, timer_bus.psel, gpio_bus.psel}));

    setup_before_access_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i && penable_i |-> $past(psel_i && !penable_i));

    word_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i |-> paddr_i.raw[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
// Interrupt controller for one target with level gateways and claim/complete
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

module irq_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    apb_if.slave                        bus,
    input  logic [`PERIPH_NUM_SRC-1:0]  irq_sources_i,
    output logic                        irq_o
);

    import periph_irq_pkg::*;

    localparam int NUM_SRC = `PERIPH_NUM_SRC;
    localparam int ID_W    = $bits(src_id_t);
    localparam int OFF_W   = `PERIPH_OFFSET_W;

    localparam logic [OFF_W-1:0] OFF_ENABLE    = 'h100;
    localparam logic [OFF_W-1:0] OFF_PENDING   = 'h104;
    localparam logic [OFF_W-1:0] OFF_THRESHOLD = 'h200;
    localparam logic [OFF_W-1:0] OFF_CLAIM     = 'h204;

    // Source 0 never takes part
    localparam logic [NUM_SRC-1:0] SRC_MASK = {{(NUM_SRC-1){1'b1}}, 1'b0};

    prio_t                  prio_q [NUM_SRC];
    prio_t                  threshold_q;
    logic [NUM_SRC-1:0]     enable_q;
    logic [NUM_SRC-1:0]     pending_q;
    logic [NUM_SRC-1:0]     in_service_q;
    logic                   irq_q;
    logic                   acc_rd;
    logic                   acc_wr;
    logic                   claim_rd;
    logic                   complete_wr;
    logic                   prio_hit;
    src_id_t                best_id;
    prio_t                  best_prio;
    src_id_t                complete_id;
    logic [NUM_SRC-1:0]     claim_mask;
    logic [NUM_SRC-1:0]     complete_mask;
    logic [NUM_SRC-1:0]     gate_set;

    assign acc_rd      = bus.psel && bus.penable && !bus.pwrite;
    assign acc_wr      = bus.psel && bus.penable && bus.pwrite;
    assign claim_rd    = acc_rd && (bus.paddr == OFF_CLAIM);
    assign complete_wr = acc_wr && (bus.paddr == OFF_CLAIM);
    assign prio_hit    = (bus.paddr[OFF_W-1:2+ID_W] == '0);
    assign complete_id = bus.pwdata[ID_W-1:0];

    // Level gateways hold off while the source is in service
    assign gate_set = irq_sources_i & ~in_service_q & SRC_MASK;

    // Highest priority wins, ties go to the lower id, priority 0 never wins
    always_comb begin
        best_id   = SRC_NONE;
        best_prio = '0;
        for (int i = 1; i < NUM_SRC; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        if (claim_rd) begin
            claim_mask[best_id] = 1'b1;
        end
        if (complete_wr) begin
            complete_mask[complete_id] = 1'b1;
        end
        claim_mask = claim_mask & SRC_MASK;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            threshold_q  <= '0;
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            irq_q        <= 1'b0;
        end else begin
            pending_q    <= (pending_q | gate_set) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            irq_q        <= (best_prio > threshold_q);
            if (acc_wr) begin
                if (prio_hit) begin
                    prio_q[bus.paddr[2 +: ID_W]] <= bus.pwdata[`PERIPH_PRIO_W-1:0];
                end else if (bus.paddr == OFF_ENABLE) begin
                    enable_q <= bus.pwdata[NUM_SRC-1:0];
                end else if (bus.paddr == OFF_THRESHOLD) begin
                    threshold_q <= bus.pwdata[`PERIPH_PRIO_W-1:0];
                end
            end
        end
    end

    always_comb begin
        bus.prdata = '0;
        if (prio_hit) begin
            bus.prdata[`PERIPH_PRIO_W-1:0] = prio_q[bus.paddr[2 +: ID_W]];
        end else begin
            case (bus.paddr)
                OFF_ENABLE:    bus.prdata[NUM_SRC-1:0]        = enable_q;
                OFF_PENDING:   bus.prdata[NUM_SRC-1:0]        = pending_q;
                OFF_THRESHOLD: bus.prdata[`PERIPH_PRIO_W-1:0] = threshold_q;
                OFF_CLAIM:     bus.prdata[ID_W-1:0]           = best_id;
                default: ;
            endcase
        end
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;
    assign irq_o       = irq_q;

    claim_while_irq_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        claim_rd && irq_o |-> best_id != SRC_NONE);

endmodule

`default_nettype wire

// ==== source/apb_timer.sv ====
// Periodic compare timers with sticky match status as interrupt level
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

module apb_timer (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    apb_if.slave                            bus,
    output logic [`PERIPH_TIMER_CNT-1:0]    irq_o
);

    localparam int CNT   = `PERIPH_TIMER_CNT;
    localparam int DW    = `PERIPH_DATA_W;
    localparam int IDX_W = (CNT > 1) ? $clog2(CNT) : 1;

    localparam logic [1:0] REG_COUNT   = 2'd0;
    localparam logic [1:0] REG_CTRL    = 2'd1;
    localparam logic [1:0] REG_COMPARE = 2'd2;
    localparam logic [1:0] REG_STATUS  = 2'd3;

    logic [DW-1:0]      count_q   [CNT];
    logic [DW-1:0]      compare_q [CNT];
    logic [CNT-1:0]     enable_q;
    logic [CNT-1:0]     status_q;
    logic [IDX_W-1:0]   idx;
    logic [1:0]         reg_sel;
    logic               sel_ok;
    logic               acc_wr;

    // Timer n at offset 0x10 * n, four words each
    assign idx     = bus.paddr[4 +: IDX_W];
    assign reg_sel = bus.paddr[3:2];
    assign sel_ok  = (bus.paddr[`PERIPH_OFFSET_W-1:4+IDX_W] == '0) && (int'(idx) < CNT);
    assign acc_wr  = bus.psel && bus.penable && bus.pwrite && sel_ok;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int n = 0; n < CNT; n++) begin
                count_q[n]   <= '0;
                compare_q[n] <= '0;
            end
            enable_q <= '0;
            status_q <= '0;
        end else begin
            for (int n = 0; n < CNT; n++) begin
                // New compare value restarts the period
                if (acc_wr && (int'(idx) == n) && (reg_sel == REG_COMPARE)) begin
                    compare_q[n] <= bus.pwdata;
                    count_q[n]   <= '0;
                end else if (enable_q[n]) begin
                    if (count_q[n] == compare_q[n]) begin
                        count_q[n] <= '0;
                    end else begin
                        count_q[n] <= count_q[n] + 1'b1;
                    end
                end
                if (acc_wr && (int'(idx) == n) && (reg_sel == REG_CTRL)) begin
                    enable_q[n] <= bus.pwdata[0];
                end
                // A new match wins over a clear in the same cycle
                if (enable_q[n] && (count_q[n] == compare_q[n])) begin
                    status_q[n] <= 1'b1;
                end else if (acc_wr && (int'(idx) == n) && (reg_sel == REG_STATUS)
                             && bus.pwdata[0]) begin
                    status_q[n] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        bus.prdata = '0;
        if (sel_ok) begin
            case (reg_sel)
                REG_COUNT:   bus.prdata    = count_q[idx];
                REG_CTRL:    bus.prdata[0] = enable_q[idx];
                REG_COMPARE: bus.prdata    = compare_q[idx];
                REG_STATUS:  bus.prdata[0] = status_q[idx];
                default: ;
            endcase
        end
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;
    assign irq_o       = status_q;

    for (genvar n = 0; n < CNT; n++) begin : gen_chk
        count_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            enable_q[n] |-> count_q[n] <= compare_q[n]);
    end

endmodule

`default_nettype wire

// ==== source/gpio_regs.sv ====
// LED output register and synchronized DIP switch input
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

module gpio_regs (
    input  logic        clk_i,
    input  logic        rst_n_i,
    apb_if.slave        bus,
    output logic [7:0]  leds_o,
    input  logic [7:0]  dip_switches_i
);

    localparam logic [`PERIPH_OFFSET_W-1:0] OFF_LEDS = 'h0;
    localparam logic [`PERIPH_OFFSET_W-1:0] OFF_DIP  = 'h4;

    logic [7:0] leds_q;
    logic [7:0] dip_meta_q;
    logic [7:0] dip_sync_q;
    logic       led_wr;

    assign led_wr = bus.psel && bus.penable && bus.pwrite && (bus.paddr == OFF_LEDS);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            leds_q     <= '0;
            dip_meta_q <= '0;
            dip_sync_q <= '0;
        end else begin
            // Two flops against metastability on the switches
            dip_meta_q <= dip_switches_i;
            dip_sync_q <= dip_meta_q;
            if (led_wr) begin
                leds_q <= bus.pwdata[7:0];
            end
        end
    end

    always_comb begin
        bus.prdata = '0;
        case (bus.paddr)
            OFF_LEDS: bus.prdata[7:0] = leds_q;
            OFF_DIP:  bus.prdata[7:0] = dip_sync_q;
            default: ;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;
    assign leds_o      = leds_q;

endmodule

`default_nettype wire

// ==== source/periph_top.sv ====
// Peripheral subsystem with interrupt controller, timers and GPIO on one APB port
`timescale 1ns/1ns
`default_nettype none

`include "periph_cfg.svh"

module periph_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // APB target
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`PERIPH_ADDR_W-1:0]   paddr_i,
    input  logic [`PERIPH_DATA_W-1:0]   pwdata_i,
    output logic [`PERIPH_DATA_W-1:0]   prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    // Board pins
    output logic [7:0]                  leds_o,
    input  logic [7:0]                  dip_switches_i,
    output logic                        irq_o
);

    import periph_irq_pkg::*;

    logic [`PERIPH_NUM_SRC-1:0]   irq_sources;
    logic [`PERIPH_TIMER_CNT-1:0] timer_irq;

    apb_if irq_bus ();
    apb_if timer_bus ();
    apb_if gpio_bus ();

    // Timers sit right after source 0, the rest stay low
    assign irq_sources = `PERIPH_NUM_SRC'(timer_irq) << TIMER_FIRST_SRC;

    apb_decoder i_apb_decoder (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .irq_bus   ( irq_bus   ),
        .timer_bus ( timer_bus ),
        .gpio_bus  ( gpio_bus  )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .bus           ( irq_bus     ),
        .irq_sources_i ( irq_sources ),
        .irq_o         ( irq_o       )
    );

    apb_timer i_apb_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .bus     ( timer_bus ),
        .irq_o   ( timer_irq )
    );

    gpio_regs i_gpio_regs (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .bus            ( gpio_bus       ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i )
    );

endmodule

`default_nettype wire

// ==== dv/tb_periph_top.sv ====
// Testbench for the peripheral subsystem, replaying operations from a stimulus file
`timescale 1ns/1ns
`default_nettype none

module tb_periph_top;

    localparam logic [31:0] ERR_DATA  = 32'hdeadbeef;
    localparam string       STIM_FILE = "dv/periph_stimulus.txt";

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  leds;
    logic [7:0]  dip;
    logic        irq;
    integer      cycle_cnt = 0;
    integer      cycle_limit = 0;

    periph_top periph_top_i (
        .clk_i          ( clk     ),
        .rst_n_i        ( rst_n   ),
        .psel_i         ( psel    ),
        .penable_i      ( penable ),
        .pwrite_i       ( pwrite  ),
        .paddr_i        ( paddr   ),
        .pwdata_i       ( pwdata  ),
        .prdata_o       ( prdata  ),
        .pready_o       ( pready  ),
        .pslverr_o      ( pslverr ),
        .leds_o         ( leds    ),
        .dip_switches_i ( dip     ),
        .irq_o          ( irq     )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            report_error("Run exceeded its cycle limit");
        end
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // Regions 3 and up have no peripheral
    function automatic logic region_unmapped(input logic [15:0] addr);
        return addr[15:12] > 4'd2;
    endfunction

    // ------------------------------
    // Bus and pin helpers
    // ------------------------------
    task automatic apb_transfer(input logic write, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        // Zero wait states, so the access cycle always completes
        check_value("pready_o", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_irq(input logic exp, input integer max_cycles);
        integer n;
        n = 0;
        @(negedge clk);
        while (irq !== exp && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (irq !== exp) begin
            report_error($sformatf("irq_o did not reach %0b within %0d cycles", exp, max_cycles));
        end
    endtask

    task automatic read_hex(input integer fd, output logic [31:0] value);
        integer code;
        code = $fscanf(fd, "%h", value);
        if (code != 1) begin
            report_error("Stimulus file has a missing or bad hex field");
        end
    endtask

    initial begin : main_seq
        integer           fd;
        integer           code;
        integer           nlines;
        logic [8*16-1:0]  tok;
        logic [8*256-1:0] line;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      rdata;
        logic             err;
        logic             done;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        dip     = '0;
        nlines  = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_error("Cannot open the stimulus file dv/periph_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            nlines++;
        end
        $fclose(fd);
        cycle_limit = 16 + nlines * 260;
        fd = $fopen(STIM_FILE, "r");

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (tok)
                    "#": code = $fgets(line, fd);
                    "W": begin
                        read_hex(fd, f1);
                        read_hex(fd, f2);
                        apb_transfer(1'b1, f1[15:0], f2, rdata, err);
                        check_value("pslverr_o", err, region_unmapped(f1[15:0]));
                    end
                    "R": begin
                        read_hex(fd, f1);
                        read_hex(fd, f2);
                        apb_transfer(1'b0, f1[15:0], '0, rdata, err);
                        check_value("pslverr_o", err, 1'b0);
                        check_value($sformatf("prdata_o[%h]", f1[15:0]), rdata, f2);
                    end
                    "E": begin
                        read_hex(fd, f1);
                        apb_transfer(1'b0, f1[15:0], '0, rdata, err);
                        check_value("pslverr_o", err, 1'b1);
                        check_value($sformatf("prdata_o[%h]", f1[15:0]), rdata, ERR_DATA);
                    end
                    "D": begin
                        read_hex(fd, f1);
                        @(negedge clk);
                        dip = f1[7:0];
                        // Let the value pass the synchronizer
                        repeat (3) @(negedge clk);
                    end
                    "L": begin
                        read_hex(fd, f1);
                        @(negedge clk);
                        check_value("leds_o", leds, f1);
                    end
                    "I": begin
                        read_hex(fd, f1);
                        read_hex(fd, f2);
                        wait_irq(f1[0], f2);
                    end
                    default: report_error("Unknown operation in stimulus file");
                endcase
            end
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/periph_bus_pkg.sv
source/periph_irq_pkg.sv
source/apb_if.sv
source/apb_decoder.sv
source/irq_ctrl.sv
source/apb_timer.sv
source/gpio_regs.sv
source/periph_top.sv
dv/tb_periph_top.sv

// ==== dv/periph_stimulus.txt ====
# op W addr data | R addr expect | E addr | D value | L expect | I expect cycles
# Fields are hex, addr is the full 16-bit APB address
L 00
W 2000 a5
L a5
R 2000 a5
D 3c
R 2004 3c
# Regions 3 and up answer with an error
E 3000
E f004
W 3000 ff
W f100 ff
L a5
R 0100 00
# Timer 1 with compare 6, then stopped and cleared
W 1018 6
W 1014 1
R 101c 0
R 1018 6
R 101c 1
W 1014 0
W 101c 1
R 101c 0
R 1010 5
R 1010 5
# Timer 0 as source 1, source 2 still pending from timer 1
W 0004 2
W 0200 1
W 0100 2
R 0104 4
W 1008 3
W 1004 1
I 1 40
R 0104 6
R 0204 1
R 0104 4
W 1004 0
W 100c 1
W 0204 1
I 0 10
# Source 2 above source 1, then threshold at the top
W 1008 3
W 1004 1
W 0008 5
W 0100 6
R 0104 6
I 1 10
R 0204 2
W 0200 7
I 0 10
W 0004 7
I 0 4
